// File: rtl/mul_pipe.sv
// ----------------------------
// Fixed-latency two-lane multiplier; the whole pipe
// stalls while its last stage is held
// ----------------------------
`default_nettype none

module mul_pipe #(
    parameter int LATENCY = muldiv_pkg::MUL_LATENCY
) (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 in_valid,
    output logic                                                 in_ready,
    input  logic                                                 high,
    input  logic                                                 signed_a,
    input  logic                                                 signed_b,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       in_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      in_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rs1,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rs2,
    output logic                                                 out_valid,
    input  logic                                                 out_ready,
    output logic [muldiv_pkg::RD_BITS-1:0]                       out_rd,
    output logic [muldiv_pkg::WID_BITS-1:0]                      out_wid,
    output logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   out_data
);

    logic                                                advance;
    logic [muldiv_pkg::LANES-1:0][2*muldiv_pkg::XLEN-1:0] prod_d;
    logic [LATENCY-1:0]                                  valid_q;
    logic [LATENCY-1:0]                                  high_q;
    logic [muldiv_pkg::RD_BITS-1:0]                      rd_q [LATENCY];
    logic [muldiv_pkg::WID_BITS-1:0]                     wid_q [LATENCY];
    logic [muldiv_pkg::LANES-1:0][2*muldiv_pkg::XLEN-1:0] prod_q [LATENCY];

    // The pipe moves whenever its last stage is empty or drains
    assign advance  = ~valid_q[LATENCY-1] | out_ready;
    assign in_ready = advance;

    // A 33-bit sign-extended operand covers signed and unsigned inputs alike
    always_comb begin
        logic signed [muldiv_pkg::XLEN:0]     a_ext;
        logic signed [muldiv_pkg::XLEN:0]     b_ext;
        logic signed [2*muldiv_pkg::XLEN+1:0] full;
        for (int i = 0; i < muldiv_pkg::LANES; i++) begin
            a_ext     = {signed_a & rs1[i][muldiv_pkg::XLEN-1], rs1[i]};
            b_ext     = {signed_b & rs2[i][muldiv_pkg::XLEN-1], rs2[i]};
            full      = a_ext * b_ext;
            prod_d[i] = full[2*muldiv_pkg::XLEN-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= in_valid;
            for (int s = 1; s < LATENCY; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            high_q[0] <= high;
            rd_q[0]   <= in_rd;
            wid_q[0]  <= in_wid;
            prod_q[0] <= prod_d;
            for (int s = 1; s < LATENCY; s++) begin
                high_q[s] <= high_q[s-1];
                rd_q[s]   <= rd_q[s-1];
                wid_q[s]  <= wid_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign out_valid = valid_q[LATENCY-1];
    assign out_rd    = rd_q[LATENCY-1];
    assign out_wid   = wid_q[LATENCY-1];

    always_comb begin
        for (int i = 0; i < muldiv_pkg::LANES; i++) begin
            out_data[i] = high_q[LATENCY-1] ?
                prod_q[LATENCY-1][i][2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN] :
                prod_q[LATENCY-1][i][muldiv_pkg::XLEN-1:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/muldiv_ctrl.sv
// ----------------------------
// Decodes an M-extension op and steers the request
// to the multiplier or the divider
// ----------------------------
`default_nettype none

module muldiv_ctrl (
    input  logic                           req_valid,
    input  logic [muldiv_pkg::OP_BITS-1:0] req_op,
    output logic                           req_ready,
    output logic                           mul_valid,
    output logic                           mul_high,
    output logic                           mul_signed_a,
    output logic                           mul_signed_b,
    input  logic                           mul_ready,
    output logic                           div_valid,
    output logic                           div_signed,
    output logic                           div_rem,
    input  logic                           div_ready
);

    logic is_div;

    assign is_div    = req_op[muldiv_pkg::OP_BITS-1];
    assign mul_valid = req_valid & ~is_div;
    assign div_valid = req_valid & is_div;
    assign req_ready = is_div ? div_ready : mul_ready;

    always_comb begin
        mul_high     = 1'b1;
        mul_signed_a = 1'b0;
        mul_signed_b = 1'b0;
        div_signed   = 1'b0;
        div_rem      = 1'b0;
        case (req_op)
            // The low product is the same for any signedness
            muldiv_pkg::OP_MUL: mul_high = 1'b0;
            muldiv_pkg::OP_MULH: begin
                mul_signed_a = 1'b1;
                mul_signed_b = 1'b1;
            end
            muldiv_pkg::OP_MULHSU: mul_signed_a = 1'b1;
            muldiv_pkg::OP_DIV: div_signed = 1'b1;
            muldiv_pkg::OP_REM: begin
                div_signed = 1'b1;
                div_rem    = 1'b1;
            end
            muldiv_pkg::OP_REMU: div_rem = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/muldiv_pkg.sv
// ----------------------------
// Widths, op codes and timing constants shared by the
// multiply/divide unit and its testbench
// ----------------------------
`default_nettype none

package muldiv_pkg;

    localparam int XLEN     = 32;
    localparam int LANES    = 2;
    localparam int RD_BITS  = 5;
    localparam int WID_BITS = 2;
    localparam int OP_BITS  = 3;

    // The top op code bit selects the divider
    localparam logic [OP_BITS-1:0] OP_MUL    = 3'd0;
    localparam logic [OP_BITS-1:0] OP_MULH   = 3'd1;
    localparam logic [OP_BITS-1:0] OP_MULHSU = 3'd2;
    localparam logic [OP_BITS-1:0] OP_MULHU  = 3'd3;
    localparam logic [OP_BITS-1:0] OP_DIV    = 3'd4;
    localparam logic [OP_BITS-1:0] OP_DIVU   = 3'd5;
    localparam logic [OP_BITS-1:0] OP_REM    = 3'd6;
    localparam logic [OP_BITS-1:0] OP_REMU   = 3'd7;

    localparam int MUL_LATENCY = 3;
    // One quotient bit per iteration
    localparam int DIV_STEPS   = XLEN;

endpackage

`default_nettype wire

// File: rtl/muldiv_unit.sv
// ----------------------------
// Multiply/divide execution unit top; requests in,
// tagged responses out over valid/ready
// ----------------------------
`default_nettype none

module muldiv_unit (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 req_valid,
    output logic                                                 req_ready,
    input  logic [muldiv_pkg::OP_BITS-1:0]                       req_op,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       req_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      req_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   req_rs1,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   req_rs2,
    output logic                                                 rsp_valid,
    input  logic                                                 rsp_ready,
    output logic [muldiv_pkg::RD_BITS-1:0]                       rsp_rd,
    output logic [muldiv_pkg::WID_BITS-1:0]                      rsp_wid,
    output logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rsp_data
);

    logic                                               mul_valid;
    logic                                               mul_ready;
    logic                                               mul_high;
    logic                                               mul_signed_a;
    logic                                               mul_signed_b;
    logic                                               div_valid;
    logic                                               div_ready;
    logic                                               div_signed;
    logic                                               div_rem;
    logic                                               mul_out_valid;
    logic                                               mul_out_ready;
    logic [muldiv_pkg::RD_BITS-1:0]                     mul_out_rd;
    logic [muldiv_pkg::WID_BITS-1:0]                    mul_out_wid;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] mul_out_data;
    logic                                               div_out_valid;
    logic                                               div_out_ready;
    logic [muldiv_pkg::RD_BITS-1:0]                     div_out_rd;
    logic [muldiv_pkg::WID_BITS-1:0]                    div_out_wid;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] div_out_data;

    muldiv_ctrl ctrl_i (
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_ready    (req_ready),
        .mul_valid    (mul_valid),
        .mul_high     (mul_high),
        .mul_signed_a (mul_signed_a),
        .mul_signed_b (mul_signed_b),
        .mul_ready    (mul_ready),
        .div_valid    (div_valid),
        .div_signed   (div_signed),
        .div_rem      (div_rem),
        .div_ready    (div_ready)
    );

    mul_pipe #(
        .LATENCY (muldiv_pkg::MUL_LATENCY)
    ) mul_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .high      (mul_high),
        .signed_a  (mul_signed_a),
        .signed_b  (mul_signed_b),
        .in_rd     (req_rd),
        .in_wid    (req_wid),
        .rs1       (req_rs1),
        .rs2       (req_rs2),
        .out_valid (mul_out_valid),
        .out_ready (mul_out_ready),
        .out_rd    (mul_out_rd),
        .out_wid   (mul_out_wid),
        .out_data  (mul_out_data)
    );

    serial_div div_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (div_valid),
        .in_ready  (div_ready),
        .is_signed (div_signed),
        .is_rem    (div_rem),
        .in_rd     (req_rd),
        .in_wid    (req_wid),
        .rs1       (req_rs1),
        .rs2       (req_rs2),
        .out_valid (div_out_valid),
        .out_ready (div_out_ready),
        .out_rd    (div_out_rd),
        .out_wid   (div_out_wid),
        .out_data  (div_out_data)
    );

    rsp_arb arb_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_valid   (mul_out_valid),
        .a_ready   (mul_out_ready),
        .a_rd      (mul_out_rd),
        .a_wid     (mul_out_wid),
        .a_data    (mul_out_data),
        .b_valid   (div_out_valid),
        .b_ready   (div_out_ready),
        .b_rd      (div_out_rd),
        .b_wid     (div_out_wid),
        .b_data    (div_out_data),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_rd    (rsp_rd),
        .out_wid   (rsp_wid),
        .out_data  (rsp_data)
    );

endmodule

`default_nettype wire

// File: rtl/rsp_arb.sv
// ----------------------------
// Round-robin merge of two result streams into one
// registered response
// ----------------------------
`default_nettype none

module rsp_arb (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 a_valid,
    output logic                                                 a_ready,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       a_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      a_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   a_data,
    input  logic                                                 b_valid,
    output logic                                                 b_ready,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       b_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      b_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   b_data,
    output logic                                                 out_valid,
    input  logic                                                 out_ready,
    output logic [muldiv_pkg::RD_BITS-1:0]                       out_rd,
    output logic [muldiv_pkg::WID_BITS-1:0]                      out_wid,
    output logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   out_data
);

    logic load;
    logic sel_b;
    logic prio_b;

    assign load = ~out_valid | out_ready;
    // b wins when it is alone or holds the priority
    assign sel_b   = b_valid & (~a_valid | prio_b);
    assign a_ready = load & ~sel_b;
    assign b_ready = load & sel_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            prio_b    <= 1'b0;
        end else if (load) begin
            out_valid <= a_valid | b_valid;
            if (a_valid & b_valid) begin
                prio_b <= ~sel_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load & (a_valid | b_valid)) begin
            out_rd   <= sel_b ? b_rd : a_rd;
            out_wid  <= sel_b ? b_wid : a_wid;
            out_data <= sel_b ? b_data : a_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/serial_div.sv
// ----------------------------
// Bit-serial restoring divider for both lanes; holds
// one request until its result is taken
// ----------------------------
`default_nettype none

module serial_div (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 in_valid,
    output logic                                                 in_ready,
    input  logic                                                 is_signed,
    input  logic                                                 is_rem,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       in_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      in_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rs1,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rs2,
    output logic                                                 out_valid,
    input  logic                                                 out_ready,
    output logic [muldiv_pkg::RD_BITS-1:0]                       out_rd,
    output logic [muldiv_pkg::WID_BITS-1:0]                      out_wid,
    output logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   out_data
);

    logic                                               busy;
    logic                                               accept;
    logic                                               last_step;
    logic [$clog2(muldiv_pkg::DIV_STEPS+1)-1:0]         cnt;
    logic                                               is_rem_q;
    logic [muldiv_pkg::LANES-1:0]                       neg_n;
    logic [muldiv_pkg::LANES-1:0]                       neg_d;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] num_q;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] den_q;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] rem_q;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] num_d;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] rem_d;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] res_d;

    assign in_ready  = ~busy & ~out_valid;
    assign accept    = in_valid & in_ready;
    assign last_step = int'(cnt) == muldiv_pkg::DIV_STEPS;

    // num_q shifts the dividend out at the top and collects quotient bits below
    always_comb begin
        logic [muldiv_pkg::XLEN:0]   trial;
        logic [muldiv_pkg::XLEN-1:0] quo;
        for (int i = 0; i < muldiv_pkg::LANES; i++) begin
            trial = {rem_q[i], num_q[i][muldiv_pkg::XLEN-1]} - {1'b0, den_q[i]};
            if (trial[muldiv_pkg::XLEN]) begin
                rem_d[i] = {rem_q[i][muldiv_pkg::XLEN-2:0], num_q[i][muldiv_pkg::XLEN-1]};
                num_d[i] = {num_q[i][muldiv_pkg::XLEN-2:0], 1'b0};
            end else begin
                rem_d[i] = trial[muldiv_pkg::XLEN-1:0];
                num_d[i] = {num_q[i][muldiv_pkg::XLEN-2:0], 1'b1};
            end
            // Overflow needs no special case, the magnitudes already give the right bits
            quo = (neg_n[i] ^ neg_d[i]) ? -num_q[i] : num_q[i];
            if (den_q[i] == '0) begin
                quo = '1;
            end
            res_d[i] = is_rem_q ? (neg_n[i] ? -rem_q[i] : rem_q[i]) : quo;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            cnt       <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (last_step) begin
                busy      <= 1'b0;
                out_valid <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rd   <= in_rd;
            out_wid  <= in_wid;
            is_rem_q <= is_rem;
            rem_q    <= '0;
            for (int i = 0; i < muldiv_pkg::LANES; i++) begin
                neg_n[i] <= is_signed & rs1[i][muldiv_pkg::XLEN-1];
                neg_d[i] <= is_signed & rs2[i][muldiv_pkg::XLEN-1];
                num_q[i] <= (is_signed & rs1[i][muldiv_pkg::XLEN-1]) ? -rs1[i] : rs1[i];
                den_q[i] <= (is_signed & rs2[i][muldiv_pkg::XLEN-1]) ? -rs2[i] : rs2[i];
            end
        end else if (busy) begin
            if (last_step) begin
                out_data <= res_d;
            end else begin
                num_q <= num_d;
                rem_q <= rem_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the multiply/divide testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module muldiv_tb -f sources.f

sim_output=$(./obj_dir/Vmuldiv_tb)
echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST PASSED$"; then
    exit 0
else
    exit 1
fi

// File: sim/muldiv_assert.sv
// ----------------------------
// Response handshake and divider occupancy checks,
// bound into the unit's top level by the testbench
// ----------------------------
`default_nettype none

module muldiv_assert (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 rsp_valid,
    input  logic                                                 rsp_ready,
    input  logic [muldiv_pkg::RD_BITS-1:0]                       rsp_rd,
    input  logic [muldiv_pkg::WID_BITS-1:0]                      rsp_wid,
    input  logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0]   rsp_data,
    input  logic                                                 div_valid,
    input  logic                                                 div_ready,
    input  logic                                                 div_out_valid,
    input  logic                                                 div_out_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    logic div_pending;
    int   assert_errors = 0;

    // A divide occupies the divider from acceptance until its result is taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_pending <= 1'b0;
        end else if (div_valid && div_ready) begin
            div_pending <= 1'b1;
        end else if (div_out_valid && div_out_ready) begin
            div_pending <= 1'b0;
        end
    end

    held_response: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rd) && $stable(rsp_wid)
            && $stable(rsp_data))
        else begin
            $error("response dropped or changed while stalled");
            assert_errors++;
        end

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
        else begin
            $error("response valid during reset");
            assert_errors++;
        end

    single_divide: assert property (@(posedge clk) disable iff (!arst_n)
        div_pending |-> !(div_valid && div_ready))
        else begin
            $error("divider accepted a request while busy");
            assert_errors++;
        end

endmodule

`default_nettype wire

// File: sim/muldiv_tb.sv
// ----------------------------
// Testbench for the multiply/divide unit; runs a request
// table twice, the second time under random back-pressure
// ----------------------------
`default_nettype none

module muldiv_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ENTRIES = 16;
    localparam int TIMEOUT   = 200;

    logic                                               clk = 1'b0;
    logic                                               arst_n;
    logic                                               req_valid;
    logic                                               req_ready;
    logic [muldiv_pkg::OP_BITS-1:0]                     req_op;
    logic [muldiv_pkg::RD_BITS-1:0]                     req_rd;
    logic [muldiv_pkg::WID_BITS-1:0]                    req_wid;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] req_rs1;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] req_rs2;
    logic                                               rsp_valid;
    logic                                               rsp_ready = 1'b1;
    logic [muldiv_pkg::RD_BITS-1:0]                     rsp_rd;
    logic [muldiv_pkg::WID_BITS-1:0]                    rsp_wid;
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] rsp_data;

    logic [muldiv_pkg::OP_BITS-1:0]                     tab_op [N_ENTRIES];
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] tab_rs1 [N_ENTRIES];
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] tab_rs2 [N_ENTRIES];
    logic [muldiv_pkg::LANES-1:0][muldiv_pkg::XLEN-1:0] tab_exp [N_ENTRIES];
    int                                                 got_phase [N_ENTRIES];
    int                                                 phase;
    int                                                 received;
    int                                                 last_mul_key;
    int                                                 value_errors;
    int                                                 order_errors;
    int                                                 flow_errors;
    int                                                 seed = 51543;
    logic                                               back_pressure;
    logic                                               timed_out;

    muldiv_unit dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req_op),
        .req_rd    (req_rd),
        .req_wid   (req_wid),
        .req_rs1   (req_rs1),
        .req_rs2   (req_rs2),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rd    (rsp_rd),
        .rsp_wid   (rsp_wid),
        .rsp_data  (rsp_data)
    );

    bind muldiv_unit muldiv_assert assert_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rd        (rsp_rd),
        .rsp_wid       (rsp_wid),
        .rsp_data      (rsp_data),
        .div_valid     (div_valid),
        .div_ready     (div_ready),
        .div_out_valid (div_out_valid),
        .div_out_ready (div_out_ready)
    );

    always #20 clk = ~clk;

    // RISC-V M-extension results computed in 64-bit arithmetic
    function automatic logic [muldiv_pkg::XLEN-1:0] ref_result(
        input logic [muldiv_pkg::OP_BITS-1:0] op,
        input logic [muldiv_pkg::XLEN-1:0]    a,
        input logic [muldiv_pkg::XLEN-1:0]    b
    );
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p_ss;
        logic [63:0]        p_su;
        logic [63:0]        p_uu;
        logic signed [63:0] s_quo;
        logic signed [63:0] s_rem;
        logic               div_zero;
        logic               overflow;
        sa       = {{32{a[31]}}, a};
        sb       = {{32{b[31]}}, b};
        ua       = {32'h0, a};
        ub       = {32'h0, b};
        p_ss     = sa * sb;
        p_su     = sa * ub;
        p_uu     = ua * ub;
        div_zero = (b == 32'h0);
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        s_quo    = '0;
        s_rem    = '0;
        if (!div_zero) begin
            s_quo = sa / sb;
            s_rem = sa % sb;
        end
        case (op)
            muldiv_pkg::OP_MUL:    return p_uu[31:0];
            muldiv_pkg::OP_MULH:   return p_ss[63:32];
            muldiv_pkg::OP_MULHSU: return p_su[63:32];
            muldiv_pkg::OP_MULHU:  return p_uu[63:32];
            muldiv_pkg::OP_DIV:    return div_zero ? '1 : (overflow ? a : s_quo[31:0]);
            muldiv_pkg::OP_DIVU:   return div_zero ? '1 : a / b;
            muldiv_pkg::OP_REM:    return div_zero ? a : (overflow ? '0 : s_rem[31:0]);
            default:               return div_zero ? a : a % b;
        endcase
    endfunction

    task automatic set_entry(input int idx, input logic [muldiv_pkg::OP_BITS-1:0] op,
                             input logic [31:0] a0, input logic [31:0] b0,
                             input logic [31:0] a1, input logic [31:0] b1);
        tab_op[idx]     = op;
        tab_rs1[idx][0] = a0;
        tab_rs2[idx][0] = b0;
        tab_rs1[idx][1] = a1;
        tab_rs2[idx][1] = b1;
        tab_exp[idx][0] = ref_result(op, a0, b0);
        tab_exp[idx][1] = ref_result(op, a1, b1);
    endtask

    // Multiplies placed right after divides overtake them in flight
    task automatic fill_table();
        set_entry(0, muldiv_pkg::OP_MUL, 32'h7, 32'hffff_fffd, 32'h8000_0000, 32'h8000_0000);
        set_entry(1, muldiv_pkg::OP_MULH, 32'hffff_fffb, 32'h7, 32'h8000_0000, 32'hffff_ffff);
        set_entry(2, muldiv_pkg::OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h2);
        set_entry(3, muldiv_pkg::OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'h1234_5678,
                  32'h9abc_def0);
        set_entry(4, muldiv_pkg::OP_DIV, 32'hffff_ffec, 32'h3, 32'h100, 32'hffff_fff9);
        set_entry(5, muldiv_pkg::OP_DIVU, 32'hffff_ffec, 32'h3, 32'h100, 32'h7);
        set_entry(6, muldiv_pkg::OP_REM, 32'hffff_ffec, 32'h3, 32'h14, 32'hffff_fffd);
        set_entry(7, muldiv_pkg::OP_REMU, 32'hffff_ffec, 32'h3, 32'h100, 32'h0);
        set_entry(8, muldiv_pkg::OP_DIV, 32'h5, 32'h0, 32'h8000_0000, 32'hffff_ffff);
        set_entry(9, muldiv_pkg::OP_REM, 32'h5, 32'h0, 32'h8000_0000, 32'hffff_ffff);
        set_entry(10, muldiv_pkg::OP_MUL, 32'h4d2, 32'h162e, 32'hdead_beef, 32'h3);
        set_entry(11, muldiv_pkg::OP_MULH, 32'h7fff_ffff, 32'h7fff_ffff, 32'h8000_0000,
                  32'h7fff_ffff);
        set_entry(12, muldiv_pkg::OP_DIVU, 32'h9, 32'h0, 32'hffff_ffff, 32'h1);
        set_entry(13, muldiv_pkg::OP_MULHSU, 32'hffff_fff0, 32'h10, 32'h3, 32'h8000_0000);
        set_entry(14, muldiv_pkg::OP_REMU, 32'h8000_0000, 32'h0, 32'h13, 32'h5);
        set_entry(15, muldiv_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 32'h1234_5678);
    endtask

    task automatic check_response();
        int idx;
        int key;
        idx = int'(rsp_rd);
        key = phase * N_ENTRIES + idx;
        assert (idx < N_ENTRIES && got_phase[idx] != phase) else begin
            order_errors++;
            $display("Response for rd %0d was not expected at this point", idx);
        end
        if (idx < N_ENTRIES && got_phase[idx] != phase) begin
            got_phase[idx] = phase;
            received++;
            if (!tab_op[idx][muldiv_pkg::OP_BITS-1]) begin
                assert (key > last_mul_key) else begin
                    order_errors++;
                    $display("Multiply for rd %0d returned after a later multiply", idx);
                end
                last_mul_key = key;
            end
            assert (rsp_wid == idx[muldiv_pkg::WID_BITS-1:0]) else begin
                value_errors++;
                $display("CHECK FAILED rsp_wid for rd %0d: got %h, expected %h",
                         idx, rsp_wid, idx[muldiv_pkg::WID_BITS-1:0]);
            end
            for (int l = 0; l < muldiv_pkg::LANES; l++) begin
                assert (rsp_data[l] == tab_exp[idx][l]) else begin
                    value_errors++;
                    $display("CHECK FAILED rsp_data[%0d] for rd %0d: got %h, expected %h",
                             l, idx, rsp_data[l], tab_exp[idx][l]);
                end
            end
        end
    endtask

    // A transfer seen here completes at the next rising edge
    always @(negedge clk) begin : respond
        logic [31:0] rand_word;
        if (back_pressure) begin
            rand_word = $random(seed);
            rsp_ready = rand_word[0];
        end else begin
            rsp_ready = 1'b1;
        end
        #1;
        if (arst_n && rsp_valid && rsp_ready) begin
            check_response();
        end
    end

    task automatic send_entry(input int idx);
        int waited;
        req_valid = 1'b1;
        req_op    = tab_op[idx];
        req_rd    = idx[muldiv_pkg::RD_BITS-1:0];
        req_wid   = idx[muldiv_pkg::WID_BITS-1:0];
        req_rs1   = tab_rs1[idx];
        req_rs2   = tab_rs2[idx];
        waited    = 0;
        #1;
        while (!req_ready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (req_ready) begin
            @(negedge clk);
        end else begin
            timed_out = 1'b1;
            flow_errors++;
            $display("Request for rd %0d was never accepted", idx);
        end
        req_valid = 1'b0;
    endtask

    task automatic run_phase(input logic with_back_pressure);
        int waited;
        phase         = phase + 1;
        back_pressure = with_back_pressure;
        for (int i = 0; i < N_ENTRIES && !timed_out; i++) begin
            send_entry(i);
        end
        waited = 0;
        while (received < phase * N_ENTRIES && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (received < phase * N_ENTRIES) begin
            timed_out = 1'b1;
            $display("Responses still outstanding after %0d cycles", TIMEOUT);
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            assert (got_phase[i] == phase) else begin
                flow_errors++;
                $display("No response arrived for rd %0d", i);
            end
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        req_valid     = 1'b0;
        req_op        = '0;
        req_rd        = '0;
        req_wid       = '0;
        req_rs1       = '0;
        req_rs2       = '0;
        phase         = 0;
        flow_errors   = 0;
        back_pressure = 1'b0;
        timed_out     = 1'b0;
        fill_table();
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!rsp_valid && req_ready) else begin
            flow_errors++;
            $display("Unit is not idle after reset");
        end
        run_phase(1'b0);
        if (!timed_out) begin
            run_phase(1'b1);
        end
        $display("Errors: %0d value, %0d order, %0d flow, %0d assertion", value_errors,
                 order_errors, flow_errors, dut_i.assert_i.assert_errors);
        if (value_errors == 0 && order_errors == 0 && flow_errors == 0 && !timed_out
                && dut_i.assert_i.assert_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/muldiv_pkg.sv
rtl/muldiv_ctrl.sv
rtl/mul_pipe.sv
rtl/serial_div.sv
rtl/rsp_arb.sv
rtl/muldiv_unit.sv
sim/muldiv_assert.sv
sim/muldiv_tb.sv
